// ==== hw/vdp_cmd_pkg.sv ====
// VDP command engine definitions
`default_nettype none

package vdp_cmd_pkg;

  // Coordinate and count registers, 10 bits as on the V9938
  localparam int COORD_W = 10;
  // One pixel per byte
  localparam int COLOR_W = 8;

  // R46 writes start a command
  localparam logic [3:0] REG_CMR = 4'd14;

  // Upper nibble of R46
  typedef enum logic [3:0] {
    STOP  = 4'b0000,
    POINT = 4'b0100,
    PSET  = 4'b0101,
    LMMV  = 4'b1000,
    HMMV  = 4'b1100
  } cmd_code_t;

  // Lower three bits of R46
  typedef enum logic [2:0] {
    IMP = 3'b000,
    AND = 3'b001,
    OR  = 3'b010,
    EOR = 3'b011,
    NOT = 3'b100
  } logic_op_t;

  // CPU-visible command register set
  typedef struct packed {
    logic [COORD_W-1:0] sx;
    logic [COORD_W-1:0] sy;
    logic [COORD_W-1:0] dx;
    logic [COORD_W-1:0] dy;
    logic [COORD_W-1:0] nx;
    logic [COORD_W-1:0] ny;
    logic               dix;
    logic               diy;
    cmd_code_t          opcode;
    logic               transparent;
    logic_op_t          logop;
  } cmd_regs_t;

  typedef enum logic [3:0] {
    IDLE,
    CHK_LOOP,
    PRE_RD,
    WAIT_PRE_RD,
    WR,
    WAIT_WR,
    RD,
    WAIT_RD,
    EXEC_END
  } seq_state_t;

endpackage

`default_nettype wire

// ==== hw/vram_pkg.sv ====
// VRAM access definitions
`default_nettype none

package vram_pkg;

  // 128 KiB byte-addressed VRAM
  localparam int VRAM_ADDR_W = 17;

  // One access toward VRAM, coordinates still unpacked
  typedef struct packed {
    logic [vdp_cmd_pkg::COORD_W-1:0] x;
    logic [vdp_cmd_pkg::COORD_W-1:0] y;
    // Ignored on reads
    logic [vdp_cmd_pkg::COLOR_W-1:0] wdata;
    logic                            write;
  } vram_req_t;

endpackage

`default_nettype wire

// ==== hw/pixel_logic.sv ====
// Logical operation on one pixel
`default_nettype none

module pixel_logic import vdp_cmd_pkg::*; (
  input  logic_op_t          logop,
  input  logic               transparent,
  input  logic [COLOR_W-1:0] src,
  input  logic [COLOR_W-1:0] dst,
  output logic [COLOR_W-1:0] result
);

  always_comb begin
    // Colour 0 is see-through when TIMP and friends are selected
    if (transparent && src == '0) begin
      result = dst;
    end else begin
      case (logop)
        IMP:     result = src;
        AND:     result = src & dst;
        OR:      result = src | dst;
        EOR:     result = src ^ dst;
        NOT:     result = ~src;
        // Reserved codes keep the pixel
        default: result = dst;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/cmd_regs.sv ====
// Command register file
`default_nettype none

module cmd_regs import vdp_cmd_pkg::*; (
  input  logic               clk,
  input  logic               reset,
  input  logic               reg_wr_req,
  input  logic [3:0]         reg_num,
  input  logic [7:0]         reg_data,
  output logic               reg_wr_ack,
  output cmd_regs_t          regs,
  output logic               start,
  input  logic               clr_load,
  input  logic [COLOR_W-1:0] clr_value,
  output logic [COLOR_W-1:0] clr
);

  logic wr_pending;

  // Toggle pair, a write is waiting while the two differ
  assign wr_pending = reg_wr_req != reg_wr_ack;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      reg_wr_ack <= 1'b0;
      regs       <= '0;
      start      <= 1'b0;
      clr        <= '0;
    end else begin
      start <= 1'b0;
      // POINT result, a CPU write in the same cycle wins below
      if (clr_load) begin
        clr <= clr_value;
      end
      if (wr_pending) begin
        reg_wr_ack <= ~reg_wr_ack;
        case (reg_num)
          // R32..R43, low byte then upper bits
          4'd0:  regs.sx[7:0]         <= reg_data;
          4'd1:  regs.sx[COORD_W-1:8] <= reg_data[COORD_W-9:0];
          4'd2:  regs.sy[7:0]         <= reg_data;
          4'd3:  regs.sy[COORD_W-1:8] <= reg_data[COORD_W-9:0];
          4'd4:  regs.dx[7:0]         <= reg_data;
          4'd5:  regs.dx[COORD_W-1:8] <= reg_data[COORD_W-9:0];
          4'd6:  regs.dy[7:0]         <= reg_data;
          4'd7:  regs.dy[COORD_W-1:8] <= reg_data[COORD_W-9:0];
          4'd8:  regs.nx[7:0]         <= reg_data;
          4'd9:  regs.nx[COORD_W-1:8] <= reg_data[COORD_W-9:0];
          4'd10: regs.ny[7:0]         <= reg_data;
          4'd11: regs.ny[COORD_W-1:8] <= reg_data[COORD_W-9:0];
          // R44 colour
          4'd12: clr <= reg_data;
          // R45 direction bits
          4'd13: begin
            regs.dix <= reg_data[2];
            regs.diy <= reg_data[3];
          end
          REG_CMR: begin
            regs.opcode      <= cmd_code_t'(reg_data[7:4]);
            regs.transparent <= reg_data[3];
            regs.logop       <= logic_op_t'(reg_data[2:0]);
            // Aborts whatever runs now
            start            <= 1'b1;
          end
          default: ;
        endcase
      end
    end
  end

  // CPU keeps its toggle still until the ack has answered it
  a_req_held: assert property (@(posedge clk) disable iff (reset)
    wr_pending |=> $stable(reg_wr_req))
    else $error("register write request toggled while one was pending");

endmodule

`default_nettype wire

// ==== hw/cmd_sequencer.sv ====
// Command sequencer
`default_nettype none

module cmd_sequencer import vdp_cmd_pkg::*, vram_pkg::*; (
  input  logic               clk,
  input  logic               reset,
  input  cmd_regs_t          regs,
  input  logic               start,
  input  logic [COLOR_W-1:0] clr,
  output logic               issue,
  output vram_req_t          req,
  input  logic               done,
  input  logic [COLOR_W-1:0] rdata,
  input  logic [COLOR_W-1:0] blend,
  output logic               clr_load,
  output logic [COLOR_W-1:0] clr_value,
  output logic               ce
);

  seq_state_t         state;
  logic [COORD_W-1:0] dx_w;
  logic [COORD_W-1:0] dy_w;
  logic [COORD_W-1:0] nx_rem;
  logic [COORD_W-1:0] ny_rem;
  // First pass through CHK_LOOP after a start
  logic               init;
  // Access handed to the port and not yet done
  logic               busy;
  // Access in flight between an issue pulse and its done
  logic               in_flight;
  logic [COLOR_W-1:0] wr_data;
  logic [COORD_W-1:0] x_step;
  logic [COORD_W-1:0] y_step;
  logic               nx_end;
  logic               ny_end;

  // +1 or -1 per direction bit
  assign x_step = regs.dix ? '1 : COORD_W'(1);
  assign y_step = regs.diy ? '1 : COORD_W'(1);
  assign nx_end = nx_rem == '0;
  // One row or less left means the last row, so NY of zero gives one row
  assign ny_end = ny_rem <= COORD_W'(1);
  // Port holds read data until the next access
  assign clr_value = rdata;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= IDLE;
      ce       <= 1'b0;
      issue    <= 1'b0;
      busy     <= 1'b0;
      init     <= 1'b0;
      clr_load <= 1'b0;
      dx_w     <= '0;
      dy_w     <= '0;
      nx_rem   <= '0;
      ny_rem   <= '0;
    end else begin
      issue    <= 1'b0;
      clr_load <= 1'b0;
      if (done) begin
        busy <= 1'b0;
      end
      if (start) begin
        // Fresh working copies while any old access drains through busy
        dx_w   <= regs.dx;
        dy_w   <= regs.dy;
        nx_rem <= regs.nx;
        ny_rem <= regs.ny;
        init   <= 1'b1;
        ce     <= 1'b1;
        state  <= CHK_LOOP;
      end else begin
        case (state)
          CHK_LOOP: begin
            init <= 1'b0;
            if (!init && nx_end && ny_end) begin
              state <= EXEC_END;
            end else begin
              case (regs.opcode)
                HMMV:       state <= WR;
                LMMV, PSET: state <= PRE_RD;
                POINT:      state <= RD;
                // STOP and unsupported codes
                default:    state <= EXEC_END;
              endcase
            end
            // End of a row returns X to DX and steps Y
            if (!init && nx_end) begin
              nx_rem <= regs.nx;
              dx_w   <= regs.dx;
              ny_rem <= ny_rem - COORD_W'(1);
              dy_w   <= dy_w + y_step;
            end
          end
          PRE_RD: begin
            if (!busy) begin
              issue <= 1'b1;
              busy  <= 1'b1;
              state <= WAIT_PRE_RD;
            end
          end
          WAIT_PRE_RD: begin
            if (done) begin
              state <= WR;
            end
          end
          WR: begin
            if (!busy) begin
              issue <= 1'b1;
              busy  <= 1'b1;
              state <= WAIT_WR;
            end
          end
          WAIT_WR: begin
            if (done) begin
              if (regs.opcode == PSET) begin
                state <= EXEC_END;
              end else begin
                dx_w   <= dx_w + x_step;
                nx_rem <= nx_rem - COORD_W'(1);
                state  <= CHK_LOOP;
              end
            end
          end
          RD: begin
            if (!busy) begin
              issue <= 1'b1;
              busy  <= 1'b1;
              state <= WAIT_RD;
            end
          end
          WAIT_RD: begin
            if (done) begin
              clr_load <= 1'b1;
              state    <= EXEC_END;
            end
          end
          EXEC_END: begin
            ce    <= 1'b0;
            state <= IDLE;
          end
          default: state <= IDLE;
        endcase
      end
    end
  end

  // Write data and request payload
  always_ff @(posedge clk) begin
    case (state)
      CHK_LOOP: wr_data <= clr;
      WAIT_PRE_RD: begin
        if (done) begin
          wr_data <= blend;
        end
      end
      default: ;
    endcase
    case (state)
      PRE_RD:  req <= '{x: dx_w, y: dy_w, wdata: wr_data, write: 1'b0};
      WR:      req <= '{x: dx_w, y: dy_w, wdata: wr_data, write: 1'b1};
      RD:      req <= '{x: regs.sx, y: regs.sy, wdata: wr_data, write: 1'b0};
      default: ;
    endcase
  end

  // Outstanding access seen only through the issue and done pulses
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      in_flight <= 1'b0;
    end else if (issue) begin
      in_flight <= 1'b1;
    end else if (done) begin
      in_flight <= 1'b0;
    end
  end

  // At most one access at the port even across an abort
  a_single_access: assert property (@(posedge clk) disable iff (reset)
    issue |-> !in_flight)
    else $error("access issued while another was outstanding");

endmodule

`default_nettype wire

// ==== hw/vram_port.sv ====
// VRAM request port
`default_nettype none

module vram_port import vdp_cmd_pkg::*, vram_pkg::*; #(
  parameter int X_BITS = 8,
  parameter int Y_BITS = 9
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   issue,
  input  vram_req_t              req,
  output logic                   done,
  output logic [COLOR_W-1:0]     rdata,
  output logic                   vram_rd_req,
  output logic                   vram_wr_req,
  input  logic                   vram_rd_ack,
  input  logic                   vram_wr_ack,
  output logic [VRAM_ADDR_W-1:0] vram_addr,
  output logic [COLOR_W-1:0]     vram_wr_data,
  input  logic [COLOR_W-1:0]     vram_rd_data
);

  localparam int ADDR_W = X_BITS + Y_BITS;

  vram_req_t         req_q;
  logic              pending;
  logic              ack_match;
  logic [ADDR_W-1:0] addr;

  // Y picks the line, X the byte in it
  assign addr         = {req_q.y[Y_BITS-1:0], req_q.x[X_BITS-1:0]};
  assign vram_addr    = VRAM_ADDR_W'(addr);
  assign vram_wr_data = req_q.wdata;
  // Only the pair of the current access counts
  assign ack_match = req_q.write ? (vram_wr_req == vram_wr_ack)
                                 : (vram_rd_req == vram_rd_ack);

  always_ff @(posedge clk) begin
    if (issue) begin
      req_q <= req;
    end
    if (pending && ack_match && !req_q.write) begin
      rdata <= vram_rd_data;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      vram_rd_req <= 1'b0;
      vram_wr_req <= 1'b0;
      pending     <= 1'b0;
      done        <= 1'b0;
    end else begin
      done <= 1'b0;
      if (issue) begin
        pending <= 1'b1;
        if (req.write) begin
          vram_wr_req <= ~vram_wr_req;
        end else begin
          vram_rd_req <= ~vram_rd_req;
        end
      end else if (pending && ack_match) begin
        pending <= 1'b0;
        done    <= 1'b1;
      end
    end
  end

  // VRAM may sample the address any time before it acknowledges
  a_addr_stable: assert property (@(posedge clk) disable iff (reset)
    pending |=> $stable(vram_addr))
    else $error("VRAM address changed during a pending access");

endmodule

`default_nettype wire

// ==== hw/vdp_command_top.sv ====
// VDP command engine top level
`default_nettype none

module vdp_command_top import vdp_cmd_pkg::*, vram_pkg::*; #(
  parameter int X_BITS = 8,
  parameter int Y_BITS = 9
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   reg_wr_req,
  input  logic [3:0]             reg_num,
  input  logic [7:0]             reg_data,
  output logic                   reg_wr_ack,
  output logic                   vram_rd_req,
  input  logic                   vram_rd_ack,
  output logic                   vram_wr_req,
  input  logic                   vram_wr_ack,
  output logic [VRAM_ADDR_W-1:0] vram_addr,
  output logic [COLOR_W-1:0]     vram_wr_data,
  input  logic [COLOR_W-1:0]     vram_rd_data,
  output logic [COLOR_W-1:0]     clr,
  output logic                   ce
);

  cmd_regs_t          regs;
  logic               start;
  logic               clr_load;
  logic [COLOR_W-1:0] clr_value;
  logic               issue;
  vram_req_t          req;
  logic               done;
  logic [COLOR_W-1:0] rdata;
  logic [COLOR_W-1:0] blend;

  cmd_regs u_regs (
    .clk        (clk),
    .reset      (reset),
    .reg_wr_req (reg_wr_req),
    .reg_num    (reg_num),
    .reg_data   (reg_data),
    .reg_wr_ack (reg_wr_ack),
    .regs       (regs),
    .start      (start),
    .clr_load   (clr_load),
    .clr_value  (clr_value),
    .clr        (clr)
  );

  cmd_sequencer u_seq (
    .clk       (clk),
    .reset     (reset),
    .regs      (regs),
    .start     (start),
    .clr       (clr),
    .issue     (issue),
    .req       (req),
    .done      (done),
    .rdata     (rdata),
    .blend     (blend),
    .clr_load  (clr_load),
    .clr_value (clr_value),
    .ce        (ce)
  );

  // Source is the colour register, destination the pixel just read
  pixel_logic u_logic (
    .logop       (regs.logop),
    .transparent (regs.transparent),
    .src         (clr),
    .dst         (rdata),
    .result      (blend)
  );

  vram_port #(
    .X_BITS (X_BITS),
    .Y_BITS (Y_BITS)
  ) u_port (
    .clk          (clk),
    .reset        (reset),
    .issue        (issue),
    .req          (req),
    .done         (done),
    .rdata        (rdata),
    .vram_rd_req  (vram_rd_req),
    .vram_wr_req  (vram_wr_req),
    .vram_rd_ack  (vram_rd_ack),
    .vram_wr_ack  (vram_wr_ack),
    .vram_addr    (vram_addr),
    .vram_wr_data (vram_wr_data),
    .vram_rd_data (vram_rd_data)
  );

endmodule

`default_nettype wire

// ==== verification/vram_model.sv ====
// Behavioral VRAM with toggle handshake
`default_nettype none

module vram_model import vdp_cmd_pkg::*, vram_pkg::*; #(
  parameter logic [31:0] SEED = 32'hc8a2
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   rd_req,
  input  logic                   wr_req,
  output logic                   rd_ack,
  output logic                   wr_ack,
  input  logic [VRAM_ADDR_W-1:0] addr,
  input  logic [COLOR_W-1:0]     wr_data,
  output logic [COLOR_W-1:0]     rd_data
);

  // 128 KiB, one byte per pixel
  logic [COLOR_W-1:0] mem [0:(1 << VRAM_ADDR_W) - 1];
  // Cycles left before the acknowledge toggles
  logic [2:0]         wait_cnt;

  // Random contents, every address its own value
  initial begin
    void'($urandom(SEED));
    for (int i = 0; i < (1 << VRAM_ADDR_W); i++) begin
      mem[VRAM_ADDR_W'(i)] = COLOR_W'($urandom);
    end
  end

  always @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_ack   <= 1'b0;
      wr_ack   <= 1'b0;
      rd_data  <= '0;
      wait_cnt <= '0;
    end else if (wait_cnt != 3'd0) begin
      wait_cnt <= wait_cnt - 3'd1;
      // Last cycle of the delay, finish the access
      if (wait_cnt == 3'd1) begin
        if (rd_req != rd_ack) begin
          rd_data <= mem[addr];
          rd_ack  <= rd_req;
        end else if (wr_req != wr_ack) begin
          mem[addr] = wr_data;
          wr_ack <= wr_req;
        end
      end
    end else if (rd_req != rd_ack || wr_req != wr_ack) begin
      // New access seen, 1 to 4 cycles until the ack
      wait_cnt <= 3'($urandom_range(4, 1));
    end
  end

endmodule

`default_nettype wire

// ==== verification/tb_vdp_command.sv ====
// VDP command engine testbench
`default_nettype none

module tb_vdp_command import vdp_cmd_pkg::*, vram_pkg::*; ();

  localparam int X_BITS = 8;
  localparam int Y_BITS = 9;

  logic                   clk;
  logic                   reset;
  logic                   reg_wr_req;
  logic [3:0]             reg_num;
  logic [7:0]             reg_data;
  logic                   reg_wr_ack;
  logic                   vram_rd_req;
  logic                   vram_rd_ack;
  logic                   vram_wr_req;
  logic                   vram_wr_ack;
  logic [VRAM_ADDR_W-1:0] vram_addr;
  logic [COLOR_W-1:0]     vram_wr_data;
  logic [COLOR_W-1:0]     vram_rd_data;
  logic [COLOR_W-1:0]     clr;
  logic                   ce;

  // Expected VRAM contents
  logic [COLOR_W-1:0] shadow [0:(1 << VRAM_ADDR_W) - 1];
  // Register values last written
  logic [COORD_W-1:0] cur_sx, cur_sy, cur_dx, cur_dy, cur_nx, cur_ny;
  logic               cur_dix, cur_diy;
  logic [COLOR_W-1:0] cur_clr;
  // Set while no VRAM access may happen
  logic               quiet;
  int                 data_errors;
  int                 protocol_errors;
  int                 timeouts;

  vdp_command_top #(
    .X_BITS (X_BITS),
    .Y_BITS (Y_BITS)
  ) UUT (
    .clk          (clk),
    .reset        (reset),
    .reg_wr_req   (reg_wr_req),
    .reg_num      (reg_num),
    .reg_data     (reg_data),
    .reg_wr_ack   (reg_wr_ack),
    .vram_rd_req  (vram_rd_req),
    .vram_rd_ack  (vram_rd_ack),
    .vram_wr_req  (vram_wr_req),
    .vram_wr_ack  (vram_wr_ack),
    .vram_addr    (vram_addr),
    .vram_wr_data (vram_wr_data),
    .vram_rd_data (vram_rd_data),
    .clr          (clr),
    .ce           (ce)
  );

  vram_model #(
    .SEED (32'hc8a2)
  ) u_vram (
    .clk     (clk),
    .reset   (reset),
    .rd_req  (vram_rd_req),
    .wr_req  (vram_wr_req),
    .rd_ack  (vram_rd_ack),
    .wr_ack  (vram_wr_ack),
    .addr    (vram_addr),
    .wr_data (vram_wr_data),
    .rd_data (vram_rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Register write answered on the very next edge
  a_ack_next: assert property (@(posedge clk) disable iff (reset)
    (reg_wr_req != reg_wr_ack) |=> (reg_wr_req == reg_wr_ack))
    else begin
      protocol_errors++;
      $display("Register write at %0t was not acknowledged one cycle later", $time);
    end

  // Idle after reset and STOP, no VRAM toggles
  a_no_access: assert property (@(posedge clk) disable iff (reset)
    quiet |-> ($stable(vram_rd_req) && $stable(vram_wr_req)))
    else begin
      protocol_errors++;
      $display("VRAM request toggled at %0t while the engine should be idle", $time);
    end

  // Y selects the line, X the byte
  function automatic logic [VRAM_ADDR_W-1:0] pixel_addr(input logic [COORD_W-1:0] x,
                                                        input logic [COORD_W-1:0] y);
    return {y[Y_BITS-1:0], x[X_BITS-1:0]};
  endfunction

  // Logical operation of CLR onto the old pixel
  function automatic logic [COLOR_W-1:0] blend_pixel(input logic_op_t op, input logic transp,
                                                     input logic [COLOR_W-1:0] src,
                                                     input logic [COLOR_W-1:0] dst);
    if (transp && src == 8'h00) begin
      return dst;
    end
    case (op)
      IMP:     return src;
      AND:     return src & dst;
      OR:      return src | dst;
      EOR:     return src ^ dst;
      NOT:     return ~src;
      default: return dst;
    endcase
  endfunction

  task automatic write_reg(input logic [3:0] num, input logic [7:0] data);
    int n;
    @(posedge clk);
    reg_num    <= num;
    reg_data   <= data;
    reg_wr_req <= ~reg_wr_req;
    n = 0;
    @(negedge clk);
    while (reg_wr_ack !== reg_wr_req && n < 4) begin
      @(negedge clk);
      n++;
    end
    if (reg_wr_ack !== reg_wr_req) begin
      timeouts++;
      $display("Register %0d write got no acknowledge by %0t", num, $time);
    end
  endtask

  task automatic set_rect(input logic [COORD_W-1:0] dx, input logic [COORD_W-1:0] dy,
                          input logic [COORD_W-1:0] nx, input logic [COORD_W-1:0] ny,
                          input logic dix, input logic diy);
    write_reg(4'd4, dx[7:0]);
    write_reg(4'd5, 8'(dx[9:8]));
    write_reg(4'd6, dy[7:0]);
    write_reg(4'd7, 8'(dy[9:8]));
    write_reg(4'd8, nx[7:0]);
    write_reg(4'd9, 8'(nx[9:8]));
    write_reg(4'd10, ny[7:0]);
    write_reg(4'd11, 8'(ny[9:8]));
    // DIX in bit 2, DIY in bit 3
    write_reg(4'd13, {4'b0000, diy, dix, 2'b00});
    cur_dx  = dx;
    cur_dy  = dy;
    cur_nx  = nx;
    cur_ny  = ny;
    cur_dix = dix;
    cur_diy = diy;
  endtask

  task automatic set_source(input logic [COORD_W-1:0] sx, input logic [COORD_W-1:0] sy);
    write_reg(4'd0, sx[7:0]);
    write_reg(4'd1, 8'(sx[9:8]));
    write_reg(4'd2, sy[7:0]);
    write_reg(4'd3, 8'(sy[9:8]));
    cur_sx = sx;
    cur_sy = sy;
  endtask

  task automatic set_colour(input logic [COLOR_W-1:0] c);
    write_reg(4'd12, c);
    cur_clr = c;
  endtask

  task automatic wait_ce(input logic level, input string what);
    int n;
    n = 0;
    while (ce !== level && n < 2000) begin
      @(negedge clk);
      n++;
    end
    if (ce !== level) begin
      timeouts++;
      $display("CE never went to %0d during %s, gave up at %0t", level, what, $time);
    end
  endtask

  // R46 write, then the whole CE pulse
  task automatic run_command(input cmd_code_t op, input logic transp, input logic_op_t lop,
                             input string what);
    write_reg(REG_CMR, {op, transp, lop});
    wait_ce(1'b1, what);
    wait_ce(1'b0, what);
  endtask

  task automatic expect_rect(input logic hmmv, input logic transp, input logic_op_t lop);
    logic [COORD_W-1:0]     x;
    logic [COORD_W-1:0]     y;
    logic [VRAM_ADDR_W-1:0] a;
    y = cur_dy;
    for (int j = 0; j < int'(cur_ny); j++) begin
      x = cur_dx;
      for (int i = 0; i < int'(cur_nx); i++) begin
        a = pixel_addr(x, y);
        shadow[a] = hmmv ? cur_clr : blend_pixel(lop, transp, cur_clr, shadow[a]);
        x = cur_dix ? x - 10'd1 : x + 10'd1;
      end
      y = cur_diy ? y - 10'd1 : y + 10'd1;
    end
  endtask

  // Whole VRAM against the expected image
  task automatic check_memory(input string what);
    logic [VRAM_ADDR_W-1:0] a;
    for (int i = 0; i < (1 << VRAM_ADDR_W); i++) begin
      a = VRAM_ADDR_W'(i);
      assert (u_vram.mem[a] == shadow[a])
        else begin
          data_errors++;
          $display("[FAIL] %0t %s: byte %05h is %02h, expected %02h", $time, what, a,
                   u_vram.mem[a], shadow[a]);
        end
    end
  endtask

  initial begin
    logic [VRAM_ADDR_W-1:0] a;
    int                     k;
    data_errors     = 0;
    protocol_errors = 0;
    timeouts        = 0;
    reset           = 1'b1;
    reg_wr_req      <= 1'b0;
    reg_num         <= 4'd0;
    reg_data        <= 8'h00;
    quiet           <= 1'b1;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    assert (ce == 1'b0 && reg_wr_ack == 1'b0)
      else begin
        data_errors++;
        $display("[FAIL] %0t after reset: ce %0b, reg_wr_ack %0b", $time, ce, reg_wr_ack);
      end
    assert (vram_rd_req == vram_rd_ack && vram_wr_req == vram_wr_ack)
      else begin
        data_errors++;
        $display("[FAIL] %0t after reset: VRAM request pending", $time);
      end
    for (int i = 0; i < (1 << VRAM_ADDR_W); i++) begin
      shadow[VRAM_ADDR_W'(i)] = u_vram.mem[VRAM_ADDR_W'(i)];
    end
    repeat (4) @(posedge clk);
    quiet <= 1'b0;

    // HMMV in all four directions
    for (int d = 0; d < 4; d++) begin
      set_rect(10'(40 + 60 * d), 10'(30 + 100 * d), 10'(3 + d), 10'(2 + d), d[0], d[1]);
      set_colour(8'(8'h30 + d));
      run_command(HMMV, 1'b0, IMP, "HMMV");
      expect_rect(1'b1, 1'b0, IMP);
      check_memory("HMMV");
    end

    // LMMV, every operation, TIMP on and off, zero and nonzero CLR
    k = 0;
    for (int op = 0; op < 5; op++) begin
      for (int t = 0; t < 2; t++) begin
        for (int cz = 0; cz < 2; cz++) begin
          set_rect(10'(12 * k + 4), 10'(300 + 3 * k), 10'd3, 10'd2, k[0], k[1]);
          set_colour(cz == 1 ? 8'ha6 : 8'h00);
          run_command(LMMV, t[0], logic_op_t'(3'(op)), "LMMV");
          expect_rect(1'b0, t[0], logic_op_t'(3'(op)));
          check_memory("LMMV");
          k++;
        end
      end
    end

    // PSET touches one byte only
    for (int op = 0; op < 5; op++) begin
      set_rect(10'(100 + 7 * op), 10'(50 + op), 10'd1, 10'd1, 1'b0, 1'b0);
      set_colour(op[0] ? 8'h00 : 8'h0f);
      run_command(PSET, 1'b1, logic_op_t'(3'(op)), "PSET");
      a = pixel_addr(cur_dx, cur_dy);
      shadow[a] = blend_pixel(logic_op_t'(3'(op)), 1'b1, cur_clr, shadow[a]);
      check_memory("PSET");
    end

    // POINT, result lands in CLR
    for (int p = 0; p < 4; p++) begin
      set_source(10'(13 * p + 5), 10'(97 * p + 3));
      run_command(POINT, 1'b0, IMP, "POINT");
      a = pixel_addr(cur_sx, cur_sy);
      assert (clr == shadow[a])
        else begin
          data_errors++;
          $display("[FAIL] %0t POINT at %0d,%0d: clr %02h, expected %02h", $time,
                   cur_sx, cur_sy, clr, shadow[a]);
        end
      cur_clr = shadow[a];
      check_memory("POINT");
    end

    // STOP ends without touching VRAM
    @(posedge clk);
    quiet <= 1'b1;
    run_command(STOP, 1'b0, IMP, "STOP");
    @(posedge clk);
    quiet <= 1'b0;
    check_memory("STOP");

    $display("Errors: %0d data, %0d protocol, %0d timeout", data_errors, protocol_errors,
             timeouts);
    if (data_errors + protocol_errors + timeouts == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
hw/vdp_cmd_pkg.sv
hw/vram_pkg.sv
hw/pixel_logic.sv
hw/cmd_regs.sv
hw/cmd_sequencer.sv
hw/vram_port.sv
hw/vdp_command_top.sv
verification/vram_model.sv
verification/tb_vdp_command.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_vdp_command
FILELIST  ?= compile.f
LOG       ?= sim.log
PASS_MSG  := *** PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
